// File: Makefile
TOP := tb_obi_integ

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

# Exit status follows the search for the pass line in the simulator output
sim:
	verilator --binary --timing --assert -j 0 -f flist.f --top-module $(TOP) -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx 'TEST RESULT: PASS'

clean:
	rm -rf obj_dir

// File: dv/tb_obi_integ.sv
//////////////////////////////////////////////////
// Self-checking testbench for the two port
// integrity subsystem, default parameters
// Reads only target words written earlier, the
// memory array itself has no reset
// integrity_en changes only with nothing in flight
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_obi_integ
  import obi_integ_pkg::*;
();

  localparam int MAX_OUT   = 2;
  localparam int MEM_WORDS = 256;
  localparam int IDX_W     = $clog2(MEM_WORDS);
  localparam int N_RAND    = 40;
  // Init pass, corrupt and range phases, two random passes on both ports
  localparam int TXN_TOTAL = 2 * 16 + 6 + 4 * N_RAND;

  // One expected response, cyc is the accept cycle
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              err;
    logic              integ;
    logic              rchk_err;
    int unsigned       cyc;
  } resp_t;

  logic              clk;
  logic              rst_n;
  logic              integ_en;

  // Index 0 port A, index 1 port B
  logic              req      [2];
  logic [ADDR_W-1:0] addr     [2];
  logic              we       [2];
  logic [DATA_W-1:0] wdata    [2];
  logic [WCHK_W-1:0] wchk     [2];
  logic              integ    [2];
  logic              gnt      [2];
  logic              rvalid   [2];
  logic [DATA_W-1:0] rdata    [2];
  logic              err      [2];
  logic              integ_o  [2];
  logic              rchk_err [2];

  // Reference memory and per port response queues
  logic [DATA_W-1:0] m_data [MEM_WORDS];
  logic [WCHK_W-1:0] m_chk  [MEM_WORDS];
  resp_t             exp_q  [2][$];

  int                errors     = 0;
  int                n_resp     = 0;
  int unsigned       cyc        = 0;
  logic              last_known = 1'b0;
  logic              last_b     = 1'b0;

  obi_integ_top #(
    .MAX_OUTSTANDING (MAX_OUT),
    .MEM_WORDS       (MEM_WORDS)
  ) obi_integ_top_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .integrity_en_i (integ_en),
    .req_a_i        (req[0]),
    .addr_a_i       (addr[0]),
    .we_a_i         (we[0]),
    .wdata_a_i      (wdata[0]),
    .wchk_a_i       (wchk[0]),
    .integrity_a_i  (integ[0]),
    .gnt_a_o        (gnt[0]),
    .rvalid_a_o     (rvalid[0]),
    .rdata_a_o      (rdata[0]),
    .err_a_o        (err[0]),
    .integrity_a_o  (integ_o[0]),
    .rchk_err_a_o   (rchk_err[0]),
    .req_b_i        (req[1]),
    .addr_b_i       (addr[1]),
    .we_b_i         (we[1]),
    .wdata_b_i      (wdata[1]),
    .wchk_b_i       (wchk[1]),
    .integrity_b_i  (integ[1]),
    .gnt_b_o        (gnt[1]),
    .rvalid_b_o     (rvalid[1]),
    .rdata_b_o      (rdata[1]),
    .err_b_o        (err[1]),
    .integrity_b_o  (integ_o[1]),
    .rchk_err_b_o   (rchk_err[1])
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Odd parity bit is set when the byte holds an even number of ones
  function automatic logic [WCHK_W-1:0] odd_par(input logic [DATA_W-1:0] d);
    logic [WCHK_W-1:0] p;
    for (int i = 0; i < WCHK_W; i++) begin
      p[i] = ($countones(d[8*i +: 8]) % 2) == 0;
    end
    return p;
  endfunction

  task automatic compare_val(input string name, input logic [31:0] got,
                             input logic [31:0] expv);
    if (got !== expv) begin
      errors++;
      $display("[FAIL] t=%0t %s: got %0h, expected %0h", $time, name, got, expv);
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  // Drive one request on the falling edge, hold it until granted
  task automatic send(input int p, input logic we_v, input logic [31:0] word,
                      input logic [DATA_W-1:0] data, input logic [WCHK_W-1:0] flip,
                      input logic integ_v);
    @(negedge clk);
    req[p]   = 1'b1;
    we[p]    = we_v;
    addr[p]  = word << 2;
    wdata[p] = data;
    wchk[p]  = odd_par(data) ^ flip;
    integ[p] = integ_v;
    do begin
      @(posedge clk);
    end while (!gnt[p]);
  endtask

  task automatic idle(input int p);
    @(negedge clk);
    req[p] = 1'b0;
  endtask

  // Wait until every accepted request has its response
  task automatic drain();
    @(negedge clk);
    req[0] = 1'b0;
    req[1] = 1'b0;
    while (exp_q[0].size() != 0 || exp_q[1].size() != 0) begin
      @(negedge clk);
    end
  endtask

  task automatic run_port(input int p, input int n, input logic init);
    logic [31:0]       word;
    logic [WCHK_W-1:0] flip;
    logic              we_v;
    for (int i = 0; i < n; i++) begin
      if (init) begin
        // Own block of 8 words, written then read back in random order
        we_v = (i < 8);
        word = 32'(p * 8) + ((i < 8) ? 32'(i) : $urandom % 8);
        flip = '0;
      end else begin
        we_v = 1'($urandom);
        word = ($urandom % 8 == 0) ? MEM_WORDS + $urandom % 16 : $urandom % 17;
        flip = ($urandom % 6 == 0) ? 4'(1 << ($urandom % 4)) : 4'h0;
        if ($urandom % 4 == 0) begin
          idle(p);
        end
      end
      send(p, we_v, word, $urandom, flip, 1'($urandom));
    end
    idle(p);
  endtask

  //////////////////////////////////////////////////
  // Reference model and response checks
  //////////////////////////////////////////////////

  always @(posedge clk) begin : monitor
    logic [1:0]       elig;
    logic [1:0]       exp_gnt;
    logic [31:0]      word;
    logic [IDX_W-1:0] idx;
    resp_t            item;
    string            pn;
    if (rst_n) begin
      cyc++;
      // Queue depth equals the DUT outstanding count before this edge
      for (int p = 0; p < 2; p++) begin
        elig[p] = req[p] && (exp_q[p].size() < MAX_OUT);
      end
      exp_gnt = elig;
      if (elig == 2'b11) begin
        // The port that was not granted last takes the tie
        exp_gnt = last_b ? 2'b01 : 2'b10;
      end
      // First tie after reset may go either way, later ties alternate
      if (elig == 2'b11 && !last_known) begin
        compare_val("gnt_a ^ gnt_b", 32'(gnt[0] ^ gnt[1]), 32'd1);
      end else begin
        compare_val("gnt_a", 32'(gnt[0]), 32'(exp_gnt[0]));
        compare_val("gnt_b", 32'(gnt[1]), 32'(exp_gnt[1]));
      end
      if (gnt[0] || gnt[1]) begin
        last_known = 1'b1;
        last_b     = gnt[1];
      end
      for (int p = 0; p < 2; p++) begin
        pn = (p == 0) ? "a" : "b";
        if (rvalid[p]) begin
          if (exp_q[p].size() == 0) begin
            errors++;
            $display("Port %s gave a response with nothing outstanding at %0t", pn, $time);
          end else begin
            item = exp_q[p].pop_front();
            n_resp++;
            compare_val({"rdata_", pn}, rdata[p], item.data);
            compare_val({"err_", pn}, 32'(err[p]), 32'(item.err));
            compare_val({"integrity_", pn}, 32'(integ_o[p]), 32'(item.integ));
            compare_val({"rchk_err_", pn}, 32'(rchk_err[p]), 32'(item.rchk_err));
            compare_val({"latency_", pn}, cyc - item.cyc, 32'd2);
          end
        end
        // Accept, model updated in acceptance order
        if (req[p] && gnt[p]) begin
          word          = addr[p] >> 2;
          idx           = word[IDX_W-1:0];
          item.integ    = integ[p];
          item.cyc      = cyc;
          item.err      = (word >= MEM_WORDS);
          item.data     = '0;
          item.rchk_err = 1'b0;
          if (!item.err && we[p]) begin
            m_data[idx] = wdata[p];
            m_chk[idx]  = wchk[p];
          end else if (!item.err) begin
            item.data     = m_data[idx];
            item.rchk_err = integ_en && (m_chk[idx] != odd_par(m_data[idx]));
          end
          exp_q[p].push_back(item);
          compare_val({"outstanding_in_limit_", pn},
                      32'(exp_q[p].size() <= MAX_OUT), 32'd1);
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    void'($urandom(32'hb403_dc5e));
    rst_n    = 1'b0;
    integ_en = 1'b1;
    for (int p = 0; p < 2; p++) begin
      req[p]   = 1'b0;
      addr[p]  = '0;
      we[p]    = 1'b0;
      wdata[p] = '0;
      wchk[p]  = '0;
      integ[p] = 1'b0;
    end
    for (int i = 0; i < MEM_WORDS; i++) begin
      m_data[i] = '0;
      m_chk[i]  = '0;
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Clean write and read back on both ports
    fork
      run_port(0, 16, 1'b1);
      run_port(1, 16, 1'b1);
    join
    drain();

    // Word 16 written with a flipped check bit, read with checking on then off
    send(0, 1'b1, 32'd16, $urandom, 4'b0100, 1'b1);
    send(0, 1'b0, 32'd16, $urandom, 4'h0, 1'b0);
    drain();
    integ_en = 1'b0;
    send(0, 1'b0, 32'd16, $urandom, 4'h0, 1'b1);
    drain();
    integ_en = 1'b1;

    // Out of range write aliases word 3, which must stay untouched
    send(1, 1'b1, MEM_WORDS + 3, $urandom, 4'h0, 1'b1);
    send(1, 1'b0, MEM_WORDS + 3, $urandom, 4'h0, 1'b0);
    send(1, 1'b0, 32'd3, $urandom, 4'h0, 1'b1);
    drain();

    // Random traffic, checking on then off
    fork
      run_port(0, N_RAND, 1'b0);
      run_port(1, N_RAND, 1'b0);
    join
    drain();
    integ_en = 1'b0;
    fork
      run_port(0, N_RAND, 1'b0);
      run_port(1, N_RAND, 1'b0);
    join
    drain();

    $display("Responses checked %0d, errors %0d", n_resp, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // Generous bound, no transaction needs 20 cycles
  initial begin : watchdog
    repeat (TXN_TOTAL * 20) @(posedge clk);
    $display("Timeout after %0d cycles with the test still running", TXN_TOTAL * 20);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// File: flist.f
rtl/obi_integ_pkg.sv
rtl/obi_rchk_check.sv
rtl/obi_integrity_fifo.sv
rtl/obi_rr_arbiter.sv
rtl/obi_mem_sub.sv
rtl/obi_integ_top.sv
dv/tb_obi_integ.sv

// File: rtl/obi_integ_pkg.sv
//////////////////////////////////////////////////
// Shared widths and constants for the OBI
// integrity subsystem
// Check bits use odd parity per byte, so a zero
// byte carries a check bit of one
// The memory takes word addresses, byte bits 1:0
// of every address are ignored
//////////////////////////////////////////////////

package obi_integ_pkg;

  // Bus widths
  localparam int unsigned DATA_W   = 32;
  localparam int unsigned ADDR_W   = 32;

  // Response check bits: 3..0 data bytes, 4 the err bit
  localparam int unsigned CHK_W    = 5;
  // Write check bits from the requester, one per byte
  localparam int unsigned WCHK_W   = 4;

  localparam int unsigned PORT_CNT = 2;

  // Byte parities of an all zero data word
  localparam logic [WCHK_W-1:0] ZERO_WCHK = '1;

  // Arbiter last winner after reset, port B, so port A wins the first tie
  localparam logic LAST_WIN_RST = 1'b1;

  // Odd parity of each data byte
  function automatic logic [WCHK_W-1:0] byte_par(input logic [DATA_W-1:0] data);
    logic [WCHK_W-1:0] par;
    for (int i = 0; i < WCHK_W; i++) begin
      par[i] = ~^data[8*i +: 8];
    end
    return par;
  endfunction

endpackage

// File: rtl/obi_integ_top.sv
//////////////////////////////////////////////////
// Two port shared memory with response integrity
// Requesters hold req and attributes until gnt
// Responses two cycles after accept, in order
// integrity_en_i enables rchk checking on both ports
//////////////////////////////////////////////////

`timescale 1ns/1ps

module obi_integ_top
  import obi_integ_pkg::*;
#(
  parameter int unsigned MAX_OUTSTANDING = 2,
  parameter int unsigned MEM_WORDS       = 256
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              integrity_en_i,

  // Port A
  input  logic              req_a_i,
  input  logic [ADDR_W-1:0] addr_a_i,
  input  logic              we_a_i,
  input  logic [DATA_W-1:0] wdata_a_i,
  input  logic [WCHK_W-1:0] wchk_a_i,
  input  logic              integrity_a_i,
  output logic              gnt_a_o,
  output logic              rvalid_a_o,
  output logic [DATA_W-1:0] rdata_a_o,
  output logic              err_a_o,
  output logic              integrity_a_o,
  output logic              rchk_err_a_o,

  // Port B
  input  logic              req_b_i,
  input  logic [ADDR_W-1:0] addr_b_i,
  input  logic              we_b_i,
  input  logic [DATA_W-1:0] wdata_b_i,
  input  logic [WCHK_W-1:0] wchk_b_i,
  input  logic              integrity_b_i,
  output logic              gnt_b_o,
  output logic              rvalid_b_o,
  output logic [DATA_W-1:0] rdata_b_o,
  output logic              err_b_o,
  output logic              integrity_b_o,
  output logic              rchk_err_b_o
);

  logic              full_a;
  logic              full_b;
  logic [CHK_W-1:0]  rchk_a;
  logic [CHK_W-1:0]  rchk_b;

  // Arbiter to memory
  logic              mem_req;
  logic [ADDR_W-1:0] mem_addr;
  logic              mem_we;
  logic [DATA_W-1:0] mem_wdata;
  logic [WCHK_W-1:0] mem_wchk;
  logic              mem_rvalid;
  logic [DATA_W-1:0] mem_rdata;
  logic              mem_err;
  logic [CHK_W-1:0]  mem_rchk;

  obi_rr_arbiter #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) arbiter_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_a_i      (req_a_i),
    .addr_a_i     (addr_a_i),
    .we_a_i       (we_a_i),
    .wdata_a_i    (wdata_a_i),
    .wchk_a_i     (wchk_a_i),
    .full_a_i     (full_a),
    .gnt_a_o      (gnt_a_o),
    .req_b_i      (req_b_i),
    .addr_b_i     (addr_b_i),
    .we_b_i       (we_b_i),
    .wdata_b_i    (wdata_b_i),
    .wchk_b_i     (wchk_b_i),
    .full_b_i     (full_b),
    .gnt_b_o      (gnt_b_o),
    .mem_req_o    (mem_req),
    .mem_addr_o   (mem_addr),
    .mem_we_o     (mem_we),
    .mem_wdata_o  (mem_wdata),
    .mem_wchk_o   (mem_wchk),
    .mem_rvalid_i (mem_rvalid),
    .mem_rdata_i  (mem_rdata),
    .mem_err_i    (mem_err),
    .mem_rchk_i   (mem_rchk),
    .rvalid_a_o   (rvalid_a_o),
    .rdata_a_o    (rdata_a_o),
    .err_a_o      (err_a_o),
    .rchk_a_o     (rchk_a),
    .rvalid_b_o   (rvalid_b_o),
    .rdata_b_o    (rdata_b_o),
    .err_b_o      (err_b_o),
    .rchk_b_o     (rchk_b)
  );

  obi_mem_sub #(
    .MEM_WORDS (MEM_WORDS)
  ) mem_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_i    (mem_req),
    .addr_i   (mem_addr),
    .we_i     (mem_we),
    .wdata_i  (mem_wdata),
    .wchk_i   (mem_wchk),
    .rvalid_o (mem_rvalid),
    .rdata_o  (mem_rdata),
    .err_o    (mem_err),
    .rchk_o   (mem_rchk)
  );

  obi_integrity_fifo #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) fifo_a_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req_a_i),
    .gnt_i          (gnt_a_o),
    .we_i           (we_a_i),
    .integrity_i    (integrity_a_i),
    .integrity_en_i (integrity_en_i),
    .rvalid_i       (rvalid_a_o),
    .rdata_i        (rdata_a_o),
    .err_i          (err_a_o),
    .rchk_i         (rchk_a),
    .full_o         (full_a),
    .integrity_o    (integrity_a_o),
    .rchk_err_o     (rchk_err_a_o)
  );

  obi_integrity_fifo #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) fifo_b_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req_b_i),
    .gnt_i          (gnt_b_o),
    .we_i           (we_b_i),
    .integrity_i    (integrity_b_i),
    .integrity_en_i (integrity_en_i),
    .rvalid_i       (rvalid_b_o),
    .rdata_i        (rdata_b_o),
    .err_i          (err_b_o),
    .rchk_i         (rchk_b),
    .full_o         (full_b),
    .integrity_o    (integrity_b_o),
    .rchk_err_o     (rchk_err_b_o)
  );

endmodule

// File: rtl/obi_integrity_fifo.sv
//////////////////////////////////////////////////
// Per port integrity FIFO
// Assumes in order responses with no back-pressure
// Requester must not be granted while full_o is set
// integrity_o and rchk_err_o are combinational and
// only valid in the rvalid_i cycle
//////////////////////////////////////////////////

`timescale 1ns/1ps

module obi_integrity_fifo
  import obi_integ_pkg::*;
#(
  parameter int unsigned MAX_OUTSTANDING = 2
) (
  input  logic              clk,
  input  logic              rst_n,

  // Address phase
  input  logic              req_i,
  input  logic              gnt_i,
  input  logic              we_i,
  input  logic              integrity_i,

  // Global check enable
  input  logic              integrity_en_i,

  // Response phase
  input  logic              rvalid_i,
  input  logic [DATA_W-1:0] rdata_i,
  input  logic              err_i,
  input  logic [CHK_W-1:0]  rchk_i,

  output logic              full_o,
  output logic              integrity_o,
  output logic              rchk_err_o
);

  localparam int unsigned CNT_W = $clog2(MAX_OUTSTANDING + 1);

  logic [CNT_W-1:0]         cnt_q;
  logic                     accept;

  // Entry 0 stays zero so cnt_q indexes the oldest entry directly
  logic [MAX_OUTSTANDING:0] integ_q;
  logic [MAX_OUTSTANDING:0] store_q;

  logic                     resp_is_store;
  logic [1:0]               rchk_en;

  assign accept = req_i && gnt_i;

  //////////////////////////////////////////////////
  // Outstanding counter
  //////////////////////////////////////////////////

  // Accept and response in one cycle leave the count unchanged
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else if (accept && !rvalid_i) begin
      cnt_q <= cnt_q + 1'b1;
    end else if (!accept && rvalid_i) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign full_o = (cnt_q == CNT_W'(MAX_OUTSTANDING));

  //////////////////////////////////////////////////
  // Attribute shift register
  //////////////////////////////////////////////////

  // Newest entry lands in slot 1, older ones move up
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      integ_q <= '0;
      store_q <= '0;
    end else if (accept) begin
      for (int i = MAX_OUTSTANDING; i > 1; i--) begin
        integ_q[i] <= integ_q[i-1];
        store_q[i] <= store_q[i-1];
      end
      integ_q[1] <= integrity_i;
      store_q[1] <= we_i;
    end
  end

  // Oldest outstanding transaction
  assign integrity_o   = integ_q[cnt_q];
  assign resp_is_store = store_q[cnt_q];

  // Stores return no data, so only their err bit is checked
  assign rchk_en[0] = rvalid_i && integrity_en_i && !resp_is_store;
  assign rchk_en[1] = rvalid_i && integrity_en_i;

  obi_rchk_check rchk_check_inst (
    .resp_rdata_i (rdata_i),
    .resp_err_i   (err_i),
    .resp_rchk_i  (rchk_i),
    .enable_i     (rchk_en),
    .err_o        (rchk_err_o)
  );

  // A response needs a matching accept
  rvalid_has_entry_a: assert property (
    @(posedge clk) disable iff (!rst_n) rvalid_i |-> (cnt_q != '0)
  );

  // Arbiter must honour full_o
  cnt_in_limit_a: assert property (
    @(posedge clk) disable iff (!rst_n) cnt_q <= CNT_W'(MAX_OUTSTANDING)
  );

endmodule

// File: rtl/obi_mem_sub.sv
//////////////////////////////////////////////////
// Single port memory subordinate
// MEM_WORDS must be a power of two
// Word index above the depth gives err, no write
// Responses come two cycles after the request,
// one request accepted every cycle
//////////////////////////////////////////////////

`timescale 1ns/1ps

module obi_mem_sub
  import obi_integ_pkg::*;
#(
  parameter int unsigned MEM_WORDS = 256
) (
  input  logic              clk,
  input  logic              rst_n,

  // Request
  input  logic              req_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic              we_i,
  input  logic [DATA_W-1:0] wdata_i,
  input  logic [WCHK_W-1:0] wchk_i,

  // Response
  output logic              rvalid_o,
  output logic [DATA_W-1:0] rdata_o,
  output logic              err_o,
  output logic [CHK_W-1:0]  rchk_o
);

  localparam int unsigned IDX_W = $clog2(MEM_WORDS);

  // Data and its write check bits side by side
  logic [DATA_W-1:0] mem_data [MEM_WORDS];
  logic [WCHK_W-1:0] mem_chk  [MEM_WORDS];

  logic [IDX_W-1:0]  idx;
  logic              in_range;

  // Stage 1, read result
  logic              s1_vld_q;
  logic [DATA_W-1:0] s1_data_q;
  logic              s1_err_q;
  logic [CHK_W-1:0]  s1_rchk_q;

  // Stage 2, output register
  logic              s2_vld_q;
  logic [DATA_W-1:0] s2_data_q;
  logic              s2_err_q;
  logic [CHK_W-1:0]  s2_rchk_q;

  // Byte address bits 1:0 dropped
  assign idx      = addr_i[IDX_W+1:2];
  assign in_range = ~|addr_i[ADDR_W-1:IDX_W+2];

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (req_i && we_i && in_range) begin
      mem_data[idx] <= wdata_i;
      mem_chk[idx]  <= wchk_i;
    end
  end

  //////////////////////////////////////////////////
  // Response pipeline
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_vld_q <= 1'b0;
      s2_vld_q <= 1'b0;
    end else begin
      s1_vld_q <= req_i;
      s2_vld_q <= s1_vld_q;
    end
  end

  // Bit 4 is odd parity of err, which equals in_range
  always_ff @(posedge clk) begin
    if (req_i) begin
      if (!we_i && in_range) begin
        // Stored check bits go back untouched
        s1_data_q <= mem_data[idx];
        s1_rchk_q <= {1'b1, mem_chk[idx]};
      end else begin
        // Stores and errored reads return zero data
        s1_data_q <= '0;
        s1_rchk_q <= {in_range, ZERO_WCHK};
      end
      s1_err_q <= !in_range;
    end
    if (s1_vld_q) begin
      s2_data_q <= s1_data_q;
      s2_err_q  <= s1_err_q;
      s2_rchk_q <= s1_rchk_q;
    end
  end

  assign rvalid_o = s2_vld_q;
  assign rdata_o  = s2_data_q;
  assign err_o    = s2_err_q;
  assign rchk_o   = s2_rchk_q;

endmodule

// File: rtl/obi_rchk_check.sv
//////////////////////////////////////////////////
// Response check bit recompute and compare
// Purely combinational, err_o is only meaningful
// while the caller raises an enable bit
// enable_i[0] gates bits 3..0, enable_i[1] bit 4
//////////////////////////////////////////////////

`timescale 1ns/1ps

module obi_rchk_check
  import obi_integ_pkg::*;
(
  input  logic [DATA_W-1:0] resp_rdata_i,
  input  logic              resp_err_i,
  input  logic [CHK_W-1:0]  resp_rchk_i,
  input  logic [1:0]        enable_i,
  output logic              err_o
);

  logic [CHK_W-1:0] rchk_exp;
  logic [CHK_W-1:0] rchk_mism;
  logic             data_err;
  logic             err_bit_err;

  // Expected bits, err parity on top of the byte parities
  assign rchk_exp  = {~resp_err_i, byte_par(resp_rdata_i)};
  assign rchk_mism = rchk_exp ^ resp_rchk_i;

  // Data bytes only count when the response carries load data
  assign data_err    = enable_i[0] && (|rchk_mism[3:0]);
  // The err bit is covered on every response
  assign err_bit_err = enable_i[1] && rchk_mism[4];

  assign err_o = data_err || err_bit_err;

endmodule

// File: rtl/obi_rr_arbiter.sv
//////////////////////////////////////////////////
// Two port round-robin arbiter
// Grant is combinational from req and full
// Assumes a memory with a fixed two cycle latency,
// the route record is sized for exactly that
//////////////////////////////////////////////////

`timescale 1ns/1ps

module obi_rr_arbiter
  import obi_integ_pkg::*;
#(
  parameter int unsigned MAX_OUTSTANDING = 2
) (
  input  logic              clk,
  input  logic              rst_n,

  // Port A request
  input  logic              req_a_i,
  input  logic [ADDR_W-1:0] addr_a_i,
  input  logic              we_a_i,
  input  logic [DATA_W-1:0] wdata_a_i,
  input  logic [WCHK_W-1:0] wchk_a_i,
  input  logic              full_a_i,
  output logic              gnt_a_o,

  // Port B request
  input  logic              req_b_i,
  input  logic [ADDR_W-1:0] addr_b_i,
  input  logic              we_b_i,
  input  logic [DATA_W-1:0] wdata_b_i,
  input  logic [WCHK_W-1:0] wchk_b_i,
  input  logic              full_b_i,
  output logic              gnt_b_o,

  // Memory request
  output logic              mem_req_o,
  output logic [ADDR_W-1:0] mem_addr_o,
  output logic              mem_we_o,
  output logic [DATA_W-1:0] mem_wdata_o,
  output logic [WCHK_W-1:0] mem_wchk_o,

  // Memory response
  input  logic              mem_rvalid_i,
  input  logic [DATA_W-1:0] mem_rdata_i,
  input  logic              mem_err_i,
  input  logic [CHK_W-1:0]  mem_rchk_i,

  // Routed responses
  output logic              rvalid_a_o,
  output logic [DATA_W-1:0] rdata_a_o,
  output logic              err_a_o,
  output logic [CHK_W-1:0]  rchk_a_o,
  output logic              rvalid_b_o,
  output logic [DATA_W-1:0] rdata_b_o,
  output logic              err_b_o,
  output logic [CHK_W-1:0]  rchk_b_o
);

  // Bit 0 port A, bit 1 port B
  logic [PORT_CNT-1:0] elig;
  // Last winner, high for port B
  logic                last_b_q;

  // Route record, index 1 is the response due this cycle
  logic [1:0]          route_vld_q;
  logic [1:0]          route_b_q;

  //////////////////////////////////////////////////
  // Grant
  //////////////////////////////////////////////////

  assign elig = {req_b_i && !full_b_i, req_a_i && !full_a_i};

  // On a tie the port that lost last time wins
  assign gnt_a_o = elig[0] && (!elig[1] || last_b_q);
  assign gnt_b_o = elig[1] && (!elig[0] || !last_b_q);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      last_b_q <= LAST_WIN_RST;
    end else if (mem_req_o) begin
      last_b_q <= gnt_b_o;
    end
  end

  // Request mux
  assign mem_req_o   = gnt_a_o || gnt_b_o;
  assign mem_addr_o  = gnt_b_o ? addr_b_i  : addr_a_i;
  assign mem_we_o    = gnt_b_o ? we_b_i    : we_a_i;
  assign mem_wdata_o = gnt_b_o ? wdata_b_i : wdata_a_i;
  assign mem_wchk_o  = gnt_b_o ? wchk_b_i  : wchk_a_i;

  //////////////////////////////////////////////////
  // Response routing
  //////////////////////////////////////////////////

  // Shifts every cycle to track the memory pipeline
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      route_vld_q <= '0;
      route_b_q   <= '0;
    end else begin
      route_vld_q <= {route_vld_q[0], mem_req_o};
      route_b_q   <= {route_b_q[0], gnt_b_o};
    end
  end

  assign rvalid_a_o = mem_rvalid_i && !route_b_q[1];
  assign rvalid_b_o = mem_rvalid_i && route_b_q[1];

  // Payload goes to both ports, rvalid picks the owner
  assign rdata_a_o = mem_rdata_i;
  assign err_a_o   = mem_err_i;
  assign rchk_a_o  = mem_rchk_i;
  assign rdata_b_o = mem_rdata_i;
  assign err_b_o   = mem_err_i;
  assign rchk_b_o  = mem_rchk_i;

  // Memory latency must match the record depth
  route_known_a: assert property (
    @(posedge clk) disable iff (!rst_n) mem_rvalid_i |-> route_vld_q[1]
  );

endmodule
